// File: run_sim.sh
#!/bin/sh
# Build the UART receiver testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module uart_rx_tb \
    -f vlog.f -o uart_rx_sim &&
./obj_dir/uart_rx_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^All tests passed$" sim.log && echo "Simulation PASSED" ||
    { echo "Simulation FAILED"; exit 1; }

// File: rx_baud_timer.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_rx_macros.svh"

module rx_baud_timer (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire uart_rx_pkg::baud_sel_t baud_select,
    input  wire logic                  timer_run,
    output logic                       vote_strobe,
    output logic                       bit_end
);

    import uart_rx_pkg::*;

    div_count_t  divisor;  // Clocks per tick for the selected rate
    div_count_t  div_cnt;
    tick_phase_t phase;
    logic        tick;
    logic        vote_phase;

    always_comb begin
        case (baud_select)
            3'd0:    divisor = div_count_t'(`RX_DIV_0);
            3'd1:    divisor = div_count_t'(`RX_DIV_1);
            3'd2:    divisor = div_count_t'(`RX_DIV_2);
            3'd3:    divisor = div_count_t'(`RX_DIV_3);
            3'd4:    divisor = div_count_t'(`RX_DIV_4);
            3'd5:    divisor = div_count_t'(`RX_DIV_5);
            3'd6:    divisor = div_count_t'(`RX_DIV_6);
            default: divisor = div_count_t'(`RX_DIV_7);
        endcase
    end

    // Tick on the first clock of each tick period
    assign tick = timer_run && (div_cnt == '0);

    assign vote_phase = (phase == tick_phase_t'(`RX_VOTE_PHASE_A)) ||
                        (phase == tick_phase_t'(`RX_VOTE_PHASE_B)) ||
                        (phase == tick_phase_t'(`RX_VOTE_PHASE_C));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt     <= '0;
            phase       <= '0;
            vote_strobe <= 1'b0;
            bit_end     <= 1'b0;
        end else if (!timer_run) begin // Held at zero so the next run starts at phase 0
            div_cnt     <= '0;
            phase       <= '0;
            vote_strobe <= 1'b0;
            bit_end     <= 1'b0;
        end else begin
            if (div_cnt == divisor - div_count_t'(1))
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + div_count_t'(1);

            if (tick)
                phase <= (phase == tick_phase_t'(`RX_OVERSAMPLE - 1)) ? '0 : phase + 1'b1;

            vote_strobe <= tick && vote_phase;
            bit_end     <= tick && (phase == tick_phase_t'(`RX_OVERSAMPLE - 1));
        end
    end

endmodule

`default_nettype wire

// File: rx_bit_sampler.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_rx_macros.svh"

module rx_bit_sampler (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic rxd,
    input  wire logic vote_strobe,
    output logic      start_edge,
    output logic      bit_value,
    output logic      bit_stable,
    output logic      bit_ready
);

    logic [`RX_SYNC_STAGES-1:0] sync_q;
    logic                       rxd_s;
    logic                       rxd_last;
    logic [1:0]                 vote_cnt;  // Votes taken for the current bit
    logic [1:0]                 samples;   // First and second vote
    logic                       last_vote;

    assign rxd_s     = sync_q[`RX_SYNC_STAGES-1];
    assign last_vote = vote_strobe && (vote_cnt == 2'd2);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_q     <= '1;   // Idle line is high
            rxd_last   <= 1'b1;
            start_edge <= 1'b0;
            vote_cnt   <= '0;
            bit_ready  <= 1'b0;
        end else begin
            sync_q     <= {sync_q[`RX_SYNC_STAGES-2:0], rxd};
            rxd_last   <= rxd_s;
            start_edge <= rxd_last && !rxd_s; // Falling edge
            bit_ready  <= last_vote;
            if (vote_strobe)
                vote_cnt <= last_vote ? 2'd0 : vote_cnt + 2'd1;
        end
    end

    // Third vote is taken straight from the line
    always_ff @(posedge clk) begin
        if (vote_strobe && !last_vote)
            samples[vote_cnt[0]] <= rxd_s;
        if (last_vote) begin
            bit_value  <= (samples[0] & samples[1]) | (samples[0] & rxd_s) |
                          (samples[1] & rxd_s);
            bit_stable <= (samples[0] == samples[1]) && (samples[1] == rxd_s);
        end
    end

endmodule

`default_nettype wire

// File: rx_frame_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module rx_frame_fsm (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic rx_en,
    input  wire logic start_edge,
    input  wire logic bit_value,
    input  wire logic bit_stable,
    input  wire logic bit_ready,
    input  wire logic bit_end,
    input  wire logic parity_odd,
    output logic      timer_run,
    output logic      shift_en,
    output logic      clear,
    output logic      load_out,
    output logic      rx_valid,
    output logic      rx_ferror,
    output logic      rx_perror
);

    import uart_rx_pkg::*;

    rx_state_t  state;
    rx_state_t  next_state;
    bit_index_t bit_idx;   // Data bit being received

    always_comb begin
        next_state = state;
        if (!rx_en) begin
            next_state = RX_DISABLED;
        end else begin
            case (state)
                RX_DISABLED: begin
                    next_state = RX_IDLE;
                end
                RX_IDLE: begin
                    if (start_edge)
                        next_state = RX_START;
                end
                RX_START: begin
                    if (bit_ready && bit_value)
                        next_state = RX_IDLE;  // Line was high mid-bit so a glitch
                    else if (bit_end)
                        next_state = RX_DATA;
                end
                RX_DATA: begin
                    if (bit_ready && !bit_stable)
                        next_state = RX_FERROR;
                    else if (bit_end && (bit_idx == '1))
                        next_state = RX_PARITY;
                end
                RX_PARITY: begin
                    if (bit_ready) begin
                        if (!bit_stable)
                            next_state = RX_FERROR;
                        else if (bit_value != parity_odd) // Even parity
                            next_state = RX_PERROR;
                    end else if (bit_end) begin
                        next_state = RX_STOP;
                    end
                end
                RX_STOP: begin
                    // Decide at mid stop bit so the next start edge is not missed
                    if (bit_ready) begin
                        if (!bit_stable || !bit_value)
                            next_state = RX_FERROR;
                        else
                            next_state = RX_IDLE;
                    end
                end
                RX_FERROR, RX_PERROR: begin
                    next_state = state; // Locked until rx_en drops
                end
                default: begin
                    next_state = RX_DISABLED;
                end
            endcase
        end
    end

    // Strobes to the shift register
    assign shift_en = (state == RX_DATA) && bit_ready;
    assign clear    = (state == RX_IDLE) && (next_state == RX_START);
    assign load_out = (state == RX_STOP) && (next_state == RX_IDLE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= RX_DISABLED;
            bit_idx   <= '0;
            timer_run <= 1'b0;
            rx_valid  <= 1'b0;
            rx_ferror <= 1'b0;
            rx_perror <= 1'b0;
        end else begin
            state <= next_state;

            if (state != RX_DATA)
                bit_idx <= '0;
            else if (bit_end)
                bit_idx <= bit_idx + 1'b1;

            timer_run <= (next_state == RX_START) || (next_state == RX_DATA) ||
                         (next_state == RX_PARITY) || (next_state == RX_STOP);
            rx_valid  <= load_out;   // One cycle per good frame
            rx_ferror <= (next_state == RX_FERROR);
            rx_perror <= (next_state == RX_PERROR);
        end
    end

endmodule

`default_nettype wire

// File: rx_shift_reg.sv
`timescale 1ns/100ps
`default_nettype none

module rx_shift_reg (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           bit_value,
    input  wire logic           shift_en,
    input  wire logic           clear,
    input  wire logic           load_out,
    output logic                parity_odd,
    output uart_rx_pkg::rx_byte_t rx_data
);

    import uart_rx_pkg::*;

    rx_byte_t shift_q;   // Byte being assembled

    // LSB arrives first and ends up in bit 0
    always_ff @(posedge clk) begin
        if (shift_en)
            shift_q <= {bit_value, shift_q[$bits(rx_byte_t)-1:1]};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            parity_odd <= 1'b0;
            rx_data    <= '0;
        end else begin
            if (clear)
                parity_odd <= 1'b0;
            else if (shift_en)
                parity_odd <= parity_odd ^ bit_value;

            if (load_out)
                rx_data <= shift_q; // Held until the next good frame
        end
    end

endmodule

`default_nettype wire

// File: uart_rx_macros.svh
`ifndef UART_RX_MACROS_SVH
`define UART_RX_MACROS_SVH

// Ticks per serial bit
`define RX_OVERSAMPLE 16

// Tick phases that take a sample, centred on the bit
`define RX_VOTE_PHASE_A 7
`define RX_VOTE_PHASE_B 8
`define RX_VOTE_PHASE_C 9

// Clocks per tick, indexed by baud select code (1.8432 MHz clock)
`define RX_DIV_0 96 // 1200 baud
`define RX_DIV_1 48 // 2400 baud
`define RX_DIV_2 24 // 4800 baud
`define RX_DIV_3 12 // 9600 baud
`define RX_DIV_4 6  // 19200 baud
`define RX_DIV_5 3  // 38400 baud
`define RX_DIV_6 2  // 57600 baud
`define RX_DIV_7 1  // 115200 baud

// Flops in front of the line sampler
`define RX_SYNC_STAGES 2

`endif

// File: uart_rx_pkg.sv
`default_nettype none

package uart_rx_pkg;

    typedef logic [2:0] baud_sel_t;   // Baud rate code
    typedef logic [7:0] rx_byte_t;    // One data byte
    typedef logic [3:0] tick_phase_t; // Tick position inside a bit
    typedef logic [6:0] div_count_t;  // Baud divider count
    typedef logic [2:0] bit_index_t;  // Data bit number

    // Frame receiver states
    typedef enum logic [2:0] {
        RX_DISABLED,
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP,
        RX_FERROR,
        RX_PERROR
    } rx_state_t;

endpackage

`default_nettype wire

// File: uart_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_tb;

    import uart_rx_pkg::*;

    localparam int FRAME_BITS = 13; // 11-bit frame and two idle bits
    // Line time of every frame sent, per rate, plus the fixed waits
    localparam int TEST_CLKS = 27 * FRAME_BITS * 16 * 1 + 20 * FRAME_BITS * 16 * 2 +
                               2 * FRAME_BITS * 16 * 12 + 1000;
    localparam int TIMEOUT_CYCLES = TEST_CLKS * 3 / 2;

    logic      clk;
    logic      reset;
    baud_sel_t baud_select;
    logic      rx_en;
    logic      rxd;
    rx_byte_t  rx_data;
    logic      rx_valid;
    logic      rx_ferror;
    logic      rx_perror;

    int          errors = 0;
    int          valid_count = 0; // rx_valid pulses since the last clear
    int          cycle_count = 0;
    logic [31:0] lcg_state;
    rx_byte_t    exp_byte;
    rx_byte_t    last_good;

    uart_rx_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .baud_select (baud_select),
        .rx_en       (rx_en),
        .rxd         (rxd),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .rx_ferror   (rx_ferror),
        .rx_perror   (rx_perror)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic note_fail(input string msg);
        errors++;
        $display("FAIL at %0t ns: %s", $time, msg);
    endtask

    // Clocks per tick for each select code
    function automatic int div_for_code(input baud_sel_t code);
        case (code)
            3'd0:    return 96;
            3'd1:    return 48;
            3'd2:    return 24;
            3'd3:    return 12;
            3'd4:    return 6;
            3'd5:    return 3;
            3'd6:    return 2;
            default: return 1;
        endcase
    endfunction

    function automatic rx_byte_t next_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    always @(posedge clk) begin
        if (rx_valid)
            valid_count++;
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timed out: the run passed %0d cycles before the tests finished",
                     cycle_count);
            $display("Errors counted: %0d", errors);
            $display("Some tests failed");
            $finish;
        end
    end

    valid_single: assert property (@(posedge clk) disable iff (reset)
        rx_valid |=> !rx_valid)
        else note_fail("rx_valid high for two cycles in a row");

    valid_data: assert property (@(posedge clk) disable iff (reset)
        rx_valid |-> (rx_data == exp_byte && !rx_ferror && !rx_perror))
        else note_fail("rx_data differs from the byte sent, or error flag with rx_valid");

    perror_hold: assert property (@(posedge clk) disable iff (reset)
        (rx_perror && rx_en) |=> (rx_perror && $stable(rx_data)))
        else note_fail("rx_perror dropped or rx_data changed while locked");

    ferror_hold: assert property (@(posedge clk) disable iff (reset)
        (rx_ferror && rx_en) |=> (rx_ferror && $stable(rx_data)))
        else note_fail("rx_ferror dropped or rx_data changed while locked");

    disabled_quiet: assert property (@(posedge clk) disable iff (reset)
        !rx_en |=> !(rx_valid || rx_ferror || rx_perror))
        else note_fail("output flag active while rx_en low");

    // One frame on the line, LSB first, even parity, then two idle bits
    task automatic send_frame(input rx_byte_t data, input logic flip_parity,
                              input logic zero_stop, input int glitch_bit);
        logic [10:0] frame;
        int          d;
        int          b;
        int          c;
        d     = div_for_code(baud_select);
        frame = {~zero_stop, (^data) ^ flip_parity, data, 1'b0};
        for (b = 0; b < 11; b++) begin
            for (c = 0; c < 16 * d; c++) begin
                // One tick period inverted around mid-bit
                if (glitch_bit >= 0 && b == glitch_bit + 1 &&
                    c >= 8 * d - d / 2 && c < 8 * d - d / 2 + d)
                    rxd = ~frame[b];
                else
                    rxd = frame[b];
                @(negedge clk);
            end
        end
        rxd = 1'b1;
        repeat (32 * d) @(negedge clk);
    endtask

    task automatic check_good(input rx_byte_t data);
        exp_byte    = data;
        valid_count = 0;
        send_frame(data, 1'b0, 1'b0, -1);
        assert (valid_count == 1 && !rx_ferror && !rx_perror)
            else note_fail($sformatf("byte %02h gave %0d valid pulses", data, valid_count));
        last_good = data;
    endtask

    task automatic check_error(input rx_byte_t data, input logic flip_parity,
                               input logic zero_stop, input int glitch_bit,
                               input logic want_perror);
        valid_count = 0;
        send_frame(data, flip_parity, zero_stop, glitch_bit);
        assert (valid_count == 0)
            else note_fail("rx_valid pulse on a bad frame");
        assert (rx_perror == want_perror && rx_ferror == !want_perror)
            else note_fail("wrong error flag after a bad frame");
        repeat (200) @(negedge clk);
        assert (rx_perror == want_perror && rx_ferror == !want_perror && rx_data == last_good)
            else note_fail("error flag or rx_data not held while locked");
        rx_en = 1'b0;
        repeat (4) @(negedge clk);
        assert (!rx_ferror && !rx_perror)
            else note_fail("error flag not cleared by rx_en low");
        rx_en = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    initial begin
        int i;
        lcg_state   = 32'h3590_3a98;
        exp_byte    = '0;
        last_good   = '0;
        reset       = 1'b1;
        rx_en       = 1'b0;
        rxd         = 1'b1; // Idle line
        baud_select = 3'd7;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk);
        assert (!rx_valid && !rx_ferror && !rx_perror && rx_data == '0)
            else note_fail("outputs not quiet after reset");
        rx_en = 1'b1;
        repeat (2) @(negedge clk);

        for (i = 0; i < 20; i++)
            check_good(next_byte());
        baud_select = 3'd6;
        for (i = 0; i < 20; i++)
            check_good(next_byte());
        baud_select = 3'd3;
        check_good(next_byte());

        baud_select = 3'd7;
        check_error(next_byte(), 1'b1, 1'b0, -1, 1'b1); // Parity flipped
        check_good(next_byte());
        check_error(next_byte(), 1'b0, 1'b1, -1, 1'b0); // Stop bit zero
        check_good(next_byte());

        // Middle vote of data bit 4 disturbed
        baud_select = 3'd3;
        check_error(next_byte(), 1'b0, 1'b0, 4, 1'b0);
        baud_select = 3'd7;
        check_good(next_byte());

        // Low pulse of a quarter bit
        valid_count = 0;
        rxd = 1'b0;
        repeat (4) @(negedge clk);
        rxd = 1'b1;
        repeat (48) @(negedge clk);
        assert (valid_count == 0 && !rx_ferror && !rx_perror)
            else note_fail("start glitch produced an output");
        check_good(next_byte());

        // Receiver off
        rx_en       = 1'b0;
        valid_count = 0;
        repeat (2) @(negedge clk);
        send_frame(next_byte(), 1'b0, 1'b0, -1);
        assert (valid_count == 0 && !rx_ferror && !rx_perror && rx_data == last_good)
            else note_fail("frame received while rx_en low");

        $display("Run complete with %0d errors", errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire uart_rx_pkg::baud_sel_t baud_select,
    input  wire logic                   rx_en,
    input  wire logic                   rxd,
    output uart_rx_pkg::rx_byte_t       rx_data,
    output logic                        rx_valid,
    output logic                        rx_ferror,
    output logic                        rx_perror
);

    logic timer_run;
    logic vote_strobe;
    logic bit_end;
    logic start_edge;
    logic bit_value;
    logic bit_stable;
    logic bit_ready;
    logic shift_en;
    logic clear;
    logic load_out;
    logic parity_odd;

    rx_baud_timer timer0 (
        .clk         (clk),
        .reset       (reset),
        .baud_select (baud_select),
        .timer_run   (timer_run),
        .vote_strobe (vote_strobe),
        .bit_end     (bit_end)
    );

    rx_bit_sampler sampler0 (
        .clk         (clk),
        .reset       (reset),
        .rxd         (rxd),
        .vote_strobe (vote_strobe),
        .start_edge  (start_edge),
        .bit_value   (bit_value),
        .bit_stable  (bit_stable),
        .bit_ready   (bit_ready)
    );

    rx_frame_fsm fsm0 (
        .clk        (clk),
        .reset      (reset),
        .rx_en      (rx_en),
        .start_edge (start_edge),
        .bit_value  (bit_value),
        .bit_stable (bit_stable),
        .bit_ready  (bit_ready),
        .bit_end    (bit_end),
        .parity_odd (parity_odd),
        .timer_run  (timer_run),
        .shift_en   (shift_en),
        .clear      (clear),
        .load_out   (load_out),
        .rx_valid   (rx_valid),
        .rx_ferror  (rx_ferror),
        .rx_perror  (rx_perror)
    );

    rx_shift_reg shift0 (
        .clk        (clk),
        .reset      (reset),
        .bit_value  (bit_value),
        .shift_en   (shift_en),
        .clear      (clear),
        .load_out   (load_out),
        .parity_odd (parity_odd),
        .rx_data    (rx_data)
    );

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
uart_rx_pkg.sv
rx_baud_timer.sv
rx_bit_sampler.sv
rx_frame_fsm.sv
rx_shift_reg.sv
uart_rx_top.sv
uart_rx_tb.sv
